/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_decode_stage
RTL_TOP    ?= decode_stage
FLIST      ?= flist.f
LOG        ?= sim.log
MAX_CYCLES ?= 0
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
PASS_MSG    = Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		-GMAX_CYCLES=$(MAX_CYCLES) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if;
   logic                   hit;
   logic                   exc_valid;
   decode_pkg::exc_cause_t exc_cause;
   logic                   is_mret;
   decode_pkg::chip_sel_t  chip_sel;
   logic                   csr_en;
   decode_pkg::csr_op_t    csr_op;
   logic                   csr_src_sel;
   decode_pkg::alu_op_t    alu_op;
   logic                   mdu_en;
   decode_pkg::mdu_op_t    mdu_op;
   logic                   rs2_negate_sel;
   logic                   reg_wr_en;
   decode_pkg::wb_sel_t    wb_sel;
   logic                   op1_sel;
   logic                   op2_sel;
   logic                   is_load;
   logic                   is_store;

   modport dec (output hit, exc_valid, exc_cause, is_mret, chip_sel, csr_en, csr_op,
                csr_src_sel, alu_op, mdu_en, mdu_op, rs2_negate_sel, reg_wr_en, wb_sel,
                op1_sel, op2_sel, is_load, is_store);
   modport sink (input hit, exc_valid, exc_cause, is_mret, chip_sel, csr_en, csr_op,
                 csr_src_sel, alu_op, mdu_en, mdu_op, rs2_negate_sel, reg_wr_en, wb_sel,
                 op1_sel, op2_sel, is_load, is_store);
endinterface

`default_nettype wire

/* common/decode_pkg.sv */
`default_nettype none

package decode_pkg;

   typedef logic [31:2] instr_t;
   typedef logic [4:0]  opcode_t;
   typedef logic [2:0]  funct3_t;
   typedef logic [6:0]  funct7_t;
   typedef logic [11:0] funct12_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [3:0]  alu_op_t;
   typedef logic [2:0]  mdu_op_t;
   typedef logic [1:0]  csr_op_t;
   typedef logic [1:0]  chip_sel_t;
   typedef logic [1:0]  wb_sel_t;
   typedef logic [3:0]  exc_cause_t;

   // Major opcodes, instruction bits 6 to 2
   localparam opcode_t OPC_LOAD   = 5'b00000;
   localparam opcode_t OPC_OP_IMM = 5'b00100;
   localparam opcode_t OPC_AUIPC  = 5'b00101;
   localparam opcode_t OPC_STORE  = 5'b01000;
   localparam opcode_t OPC_OP     = 5'b01100;
   localparam opcode_t OPC_LUI    = 5'b01101;
   localparam opcode_t OPC_BRANCH = 5'b11000;
   localparam opcode_t OPC_JALR   = 5'b11001;
   localparam opcode_t OPC_JAL    = 5'b11011;
   localparam opcode_t OPC_SYSTEM = 5'b11100;

   localparam funct3_t FUNCT3_JALR   = 3'b000;
   localparam funct3_t FUNCT3_SLL    = 3'b001;
   localparam funct3_t FUNCT3_SRL    = 3'b101;
   localparam funct3_t FUNCT3_PRIV   = 3'b000;
   localparam funct3_t FUNCT3_CSRRW  = 3'b001;
   localparam funct3_t FUNCT3_CSRRS  = 3'b010;
   localparam funct3_t FUNCT3_CSRRC  = 3'b011;
   localparam funct3_t FUNCT3_CSRRWI = 3'b101;
   localparam funct3_t FUNCT3_CSRRSI = 3'b110;
   localparam funct3_t FUNCT3_CSRRCI = 3'b111;

   localparam funct7_t FUNCT7_BASE = 7'h00;
   localparam funct7_t FUNCT7_ALT  = 7'h20;
   localparam funct7_t FUNCT7_MDU  = 7'h01;

   localparam funct12_t FUNCT12_ECALL  = 12'h000;
   localparam funct12_t FUNCT12_EBREAK = 12'h001;
   localparam funct12_t FUNCT12_MRET   = 12'h302;
   localparam funct12_t FUNCT12_WFI    = 12'h105;

   localparam alu_op_t ALU_ADD  = 4'd0;
   localparam alu_op_t ALU_SUB  = 4'd1;
   localparam alu_op_t ALU_SLL  = 4'd3;
   localparam alu_op_t ALU_SLT  = 4'd4;
   localparam alu_op_t ALU_SLTU = 4'd5;
   localparam alu_op_t ALU_XOR  = 4'd6;
   localparam alu_op_t ALU_SRL  = 4'd7;
   localparam alu_op_t ALU_SRA  = 4'd8;
   localparam alu_op_t ALU_OR   = 4'd9;
   localparam alu_op_t ALU_AND  = 4'd10;
   localparam alu_op_t ALU_LUI  = 4'd12;

   localparam csr_op_t CSR_WRITE = 2'd1;
   localparam csr_op_t CSR_SET   = 2'd2;
   localparam csr_op_t CSR_CLEAR = 2'd3;

   // Code 2 is reserved
   localparam chip_sel_t CHIP_ALU = 2'd0;
   localparam chip_sel_t CHIP_MDU = 2'd1;
   localparam chip_sel_t CHIP_CSR = 2'd3;

   localparam wb_sel_t WB_ALU = 2'd0;
   localparam wb_sel_t WB_MEM = 2'd1;
   localparam wb_sel_t WB_PC4 = 2'd3;

   localparam exc_cause_t EXC_ILLEGAL    = 4'd2;
   localparam exc_cause_t EXC_BREAKPOINT = 4'd3;
   localparam exc_cause_t EXC_ECALL      = 4'd11;

   // Registered control word: enable and flag bits on top, payload below
   localparam int CTRL_FLAG_W = 7;
   localparam int CTRL_DATA_W = 21;
   typedef logic [CTRL_FLAG_W+CTRL_DATA_W-1:0] ctrl_word_t;

   localparam ctrl_word_t ILLEGAL_CTRL = {7'b100_0000, EXC_ILLEGAL, 17'd0};

endpackage

`default_nettype wire

/* decoder/int_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module int_decoder (
   input  decode_pkg::instr_t instr_i,
   input  logic               m_ext_en_i,
   ctrl_if.dec                ctrl
);

   decode_pkg::opcode_t opcode;
   decode_pkg::funct3_t funct3;
   decode_pkg::funct7_t funct7;

   assign opcode = instr_i[6:2];
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];

   // ALU operation selected by funct3 alone
   function automatic decode_pkg::alu_op_t base_alu_op(input decode_pkg::funct3_t f3);
      case (f3)
         3'd0:    base_alu_op = decode_pkg::ALU_ADD;
         3'd1:    base_alu_op = decode_pkg::ALU_SLL;
         3'd2:    base_alu_op = decode_pkg::ALU_SLT;
         3'd3:    base_alu_op = decode_pkg::ALU_SLTU;
         3'd4:    base_alu_op = decode_pkg::ALU_XOR;
         3'd5:    base_alu_op = decode_pkg::ALU_SRL;
         3'd6:    base_alu_op = decode_pkg::ALU_OR;
         default: base_alu_op = decode_pkg::ALU_AND;
      endcase
   endfunction

   always_comb begin
      ctrl.hit            = 1'b0;
      ctrl.exc_valid      = 1'b0;
      ctrl.exc_cause      = '0;
      ctrl.is_mret        = 1'b0;
      ctrl.chip_sel       = decode_pkg::CHIP_ALU;
      ctrl.csr_en         = 1'b0;
      ctrl.csr_op         = '0;
      ctrl.csr_src_sel    = 1'b0;
      ctrl.alu_op         = decode_pkg::ALU_ADD;
      ctrl.mdu_en         = 1'b0;
      ctrl.mdu_op         = '0;
      ctrl.rs2_negate_sel = 1'b0;
      ctrl.reg_wr_en      = 1'b0;
      ctrl.wb_sel         = decode_pkg::WB_ALU;
      ctrl.op1_sel        = 1'b0;
      ctrl.op2_sel        = 1'b0;
      ctrl.is_load        = 1'b0;
      ctrl.is_store       = 1'b0;

      case (opcode)
         decode_pkg::OPC_LOAD: begin
            ctrl.hit       = funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
            ctrl.reg_wr_en = 1'b1;
            ctrl.wb_sel    = decode_pkg::WB_MEM;
            ctrl.op2_sel   = 1'b1;
            ctrl.is_load   = 1'b1;
         end
         decode_pkg::OPC_STORE: begin
            ctrl.hit      = funct3 inside {3'd0, 3'd1, 3'd2};
            ctrl.op2_sel  = 1'b1;
            ctrl.is_store = 1'b1;
         end
         decode_pkg::OPC_BRANCH: begin
            // BEQ, BNE, BLT, BGE, BLTU, BGEU
            ctrl.hit     = !(funct3 inside {3'd2, 3'd3});
            ctrl.op1_sel = 1'b1;
            ctrl.op2_sel = 1'b1;
         end
         decode_pkg::OPC_LUI: begin
            ctrl.hit       = 1'b1;
            ctrl.alu_op    = decode_pkg::ALU_LUI;
            ctrl.reg_wr_en = 1'b1;
            ctrl.op2_sel   = 1'b1;
         end
         decode_pkg::OPC_AUIPC, decode_pkg::OPC_JAL, decode_pkg::OPC_JALR: begin
            ctrl.hit       = (opcode != decode_pkg::OPC_JALR) ||
                             (funct3 == decode_pkg::FUNCT3_JALR);
            ctrl.reg_wr_en = 1'b1;
            ctrl.wb_sel    = (opcode == decode_pkg::OPC_AUIPC) ? decode_pkg::WB_ALU
                                                               : decode_pkg::WB_PC4;
            ctrl.op1_sel   = (opcode != decode_pkg::OPC_JALR);
            ctrl.op2_sel   = 1'b1;
         end
         decode_pkg::OPC_OP_IMM: begin
            if (funct3 == decode_pkg::FUNCT3_SLL) begin
               ctrl.hit = (funct7 == decode_pkg::FUNCT7_BASE);
            end else if (funct3 == decode_pkg::FUNCT3_SRL) begin
               ctrl.hit = funct7 inside {decode_pkg::FUNCT7_BASE, decode_pkg::FUNCT7_ALT};
            end else begin
               ctrl.hit = 1'b1;
            end
            ctrl.alu_op    = (funct3 == decode_pkg::FUNCT3_SRL &&
                              funct7 == decode_pkg::FUNCT7_ALT) ? decode_pkg::ALU_SRA
                                                                : base_alu_op(funct3);
            ctrl.reg_wr_en = 1'b1;
            ctrl.op2_sel   = 1'b1;
         end
         decode_pkg::OPC_OP: begin
            ctrl.reg_wr_en = 1'b1;
            case (funct7)
               decode_pkg::FUNCT7_BASE: begin
                  ctrl.hit    = 1'b1;
                  ctrl.alu_op = base_alu_op(funct3);
               end
               decode_pkg::FUNCT7_ALT: begin
                  // Only SUB and SRA use the alternate encoding
                  ctrl.hit            = funct3 inside {3'd0, decode_pkg::FUNCT3_SRL};
                  ctrl.alu_op         = (funct3 == decode_pkg::FUNCT3_SRL) ? decode_pkg::ALU_SRA
                                                                           : decode_pkg::ALU_SUB;
                  ctrl.rs2_negate_sel = (funct3 == 3'd0);
               end
               decode_pkg::FUNCT7_MDU: begin
                  ctrl.hit      = m_ext_en_i;
                  ctrl.mdu_en   = 1'b1;
                  ctrl.chip_sel = decode_pkg::CHIP_MDU;
                  ctrl.mdu_op   = funct3;
               end
               default: ;
            endcase
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

/* decoder/system_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module system_decoder (
   input  decode_pkg::instr_t instr_i,
   ctrl_if.dec                ctrl
);

   decode_pkg::opcode_t  opcode;
   decode_pkg::funct3_t  funct3;
   decode_pkg::funct12_t funct12;
   decode_pkg::reg_idx_t rd;
   decode_pkg::reg_idx_t rs1;
   logic                 is_system;

   assign opcode    = instr_i[6:2];
   assign rd        = instr_i[11:7];
   assign funct3    = instr_i[14:12];
   assign rs1       = instr_i[19:15];
   assign funct12   = instr_i[31:20];
   assign is_system = (opcode == decode_pkg::OPC_SYSTEM);

   always_comb begin
      ctrl.hit            = 1'b0;
      ctrl.exc_valid      = 1'b0;
      ctrl.exc_cause      = '0;
      ctrl.is_mret        = 1'b0;
      ctrl.chip_sel       = decode_pkg::CHIP_ALU;
      ctrl.csr_en         = 1'b0;
      ctrl.csr_op         = '0;
      ctrl.csr_src_sel    = funct3[2];
      ctrl.alu_op         = decode_pkg::ALU_ADD;
      ctrl.mdu_en         = 1'b0;
      ctrl.mdu_op         = '0;
      ctrl.rs2_negate_sel = 1'b0;
      ctrl.reg_wr_en      = 1'b0;
      ctrl.wb_sel         = decode_pkg::WB_ALU;
      ctrl.op1_sel        = 1'b0;
      ctrl.op2_sel        = 1'b0;
      ctrl.is_load        = 1'b0;
      ctrl.is_store       = 1'b0;

      case (funct3)
         decode_pkg::FUNCT3_CSRRW, decode_pkg::FUNCT3_CSRRWI: begin
            ctrl.csr_en = is_system;
            ctrl.csr_op = decode_pkg::CSR_WRITE;
         end
         decode_pkg::FUNCT3_CSRRS, decode_pkg::FUNCT3_CSRRSI: begin
            ctrl.csr_en = is_system;
            ctrl.csr_op = decode_pkg::CSR_SET;
         end
         decode_pkg::FUNCT3_CSRRC, decode_pkg::FUNCT3_CSRRCI: begin
            ctrl.csr_en = is_system;
            ctrl.csr_op = decode_pkg::CSR_CLEAR;
         end
         decode_pkg::FUNCT3_PRIV: begin
            // Privileged forms need rd and rs1 both zero
            if (is_system && rd == '0 && rs1 == '0) begin
               case (funct12)
                  decode_pkg::FUNCT12_ECALL: begin
                     ctrl.hit       = 1'b1;
                     ctrl.exc_valid = 1'b1;
                     ctrl.exc_cause = decode_pkg::EXC_ECALL;
                  end
                  decode_pkg::FUNCT12_EBREAK: begin
                     ctrl.hit       = 1'b1;
                     ctrl.exc_valid = 1'b1;
                     ctrl.exc_cause = decode_pkg::EXC_BREAKPOINT;
                  end
                  decode_pkg::FUNCT12_MRET: begin
                     ctrl.hit     = 1'b1;
                     ctrl.is_mret = 1'b1;
                  end
                  decode_pkg::FUNCT12_WFI: ctrl.hit = 1'b1;
                  default: ;
               endcase
            end
            ctrl.csr_src_sel = 1'b0;
         end
         default: ctrl.csr_src_sel = 1'b0;
      endcase

      if (ctrl.csr_en) begin
         ctrl.hit       = 1'b1;
         ctrl.chip_sel  = decode_pkg::CHIP_CSR;
         ctrl.reg_wr_en = 1'b1;
      end else if (!ctrl.hit) begin
         ctrl.csr_src_sel = 1'b0;
      end
   end

   // CSR access always routes to the CSR unit
   always_comb begin
      assert (!ctrl.csr_en || ctrl.chip_sel == decode_pkg::CHIP_CSR)
         else $error("csr_en without CSR chip select");
   end

endmodule

`default_nettype wire

/* flist.f */
common/decode_pkg.sv
common/ctrl_if.sv
decoder/int_decoder.sv
decoder/system_decoder.sv
hdl/decode_stage.sv
test/decode_checker.sv
test/tb_decode_stage.sv

/* hdl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   valid_i,
   input  decode_pkg::instr_t     instr_i,
   input  logic                   m_ext_en_i,
   output logic                   valid_o,
   output logic                   exc_valid_o,
   output decode_pkg::exc_cause_t exc_cause_o,
   output logic                   is_mret_o,
   output decode_pkg::chip_sel_t  chip_sel_o,
   output logic                   csr_en_o,
   output decode_pkg::csr_op_t    csr_op_o,
   output logic                   csr_src_sel_o,
   output decode_pkg::alu_op_t    alu_op_o,
   output logic                   mdu_en_o,
   output decode_pkg::mdu_op_t    mdu_op_o,
   output logic                   rs2_negate_sel_o,
   output logic                   reg_wr_en_o,
   output decode_pkg::wb_sel_t    wb_sel_o,
   output logic                   op1_sel_o,
   output logic                   op2_sel_o,
   output logic                   is_load_o,
   output logic                   is_store_o
);

   ctrl_if ctrl_int ();
   ctrl_if ctrl_sys ();

   decode_pkg::ctrl_word_t             int_word_w;
   decode_pkg::ctrl_word_t             sys_word_w;
   decode_pkg::ctrl_word_t             dec_word_w;
   logic [decode_pkg::CTRL_FLAG_W-1:0] flag_q;
   logic [decode_pkg::CTRL_DATA_W-1:0] data_q;

   int_decoder u_int_dec (
      .instr_i    (instr_i),
      .m_ext_en_i (m_ext_en_i),
      .ctrl       (ctrl_int)
   );

   system_decoder u_sys_dec (
      .instr_i (instr_i),
      .ctrl    (ctrl_sys)
   );

   assign int_word_w = {ctrl_int.exc_valid, ctrl_int.is_mret, ctrl_int.csr_en, ctrl_int.mdu_en,
                        ctrl_int.reg_wr_en, ctrl_int.is_load, ctrl_int.is_store,
                        ctrl_int.exc_cause, ctrl_int.chip_sel, ctrl_int.csr_op,
                        ctrl_int.csr_src_sel, ctrl_int.alu_op, ctrl_int.mdu_op,
                        ctrl_int.rs2_negate_sel, ctrl_int.wb_sel, ctrl_int.op1_sel,
                        ctrl_int.op2_sel};
   assign sys_word_w = {ctrl_sys.exc_valid, ctrl_sys.is_mret, ctrl_sys.csr_en, ctrl_sys.mdu_en,
                        ctrl_sys.reg_wr_en, ctrl_sys.is_load, ctrl_sys.is_store,
                        ctrl_sys.exc_cause, ctrl_sys.chip_sel, ctrl_sys.csr_op,
                        ctrl_sys.csr_src_sel, ctrl_sys.alu_op, ctrl_sys.mdu_op,
                        ctrl_sys.rs2_negate_sel, ctrl_sys.wb_sel, ctrl_sys.op1_sel,
                        ctrl_sys.op2_sel};

   // Nobody claimed it means illegal instruction
   assign dec_word_w = ctrl_int.hit ? int_word_w :
                       ctrl_sys.hit ? sys_word_w : decode_pkg::ILLEGAL_CTRL;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         valid_o <= 1'b0;
         flag_q  <= '0;
      end else begin
         valid_o <= valid_i;
         flag_q  <= valid_i ? dec_word_w[$bits(dec_word_w)-1 -: decode_pkg::CTRL_FLAG_W] : '0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (valid_i) begin
         data_q <= dec_word_w[decode_pkg::CTRL_DATA_W-1:0];
      end
   end

   assign {exc_valid_o, is_mret_o, csr_en_o, mdu_en_o, reg_wr_en_o, is_load_o,
           is_store_o} = flag_q;
   assign {exc_cause_o, chip_sel_o, csr_op_o, csr_src_sel_o, alu_op_o, mdu_op_o,
           rs2_negate_sel_o, wb_sel_o, op1_sel_o, op2_sel_o} = data_q;

   // Sub-decoders own disjoint opcodes
   assert property (@(posedge clk_i) disable iff (rst_i) !(ctrl_int.hit && ctrl_sys.hit))
      else $error("both sub-decoders claimed the instruction");

   assert property (@(posedge clk_i) rst_i |=> !valid_o)
      else $error("valid_o high right after reset");

endmodule

`default_nettype wire

/* test/decode_checker.sv */
`timescale 1ns/1ps
`default_nettype none

// Expected and actual words share one layout, msb first:
// exc_valid, exc_cause[4], is_mret, chip_sel[2], csr_en, csr_op[2], csr_src_sel,
// alu_op[4], mdu_en, mdu_op[3], rs2_negate_sel, reg_wr_en, wb_sel[2], op1_sel,
// op2_sel, is_load, is_store
module decode_checker (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        exp_push_i,
   input  logic [27:0] exp_word_i,
   input  logic        end_i,
   input  logic        dut_valid_i,
   input  logic [27:0] act_word_i,
   output int          checked_o,
   output int          mismatch_o,
   output int          protocol_o,
   output logic        end_done_o
);

   logic [27:0] pending_q [$];
   logic [27:0] exp_word;
   logic        pushed_last;

   task automatic compare_field(input string name, input logic [3:0] exp_val,
                                input logic [3:0] act_val);
      if (act_val !== exp_val) begin
         $display("[FAIL] %s vector %0d: expected 0x%h, got 0x%h",
                  name, checked_o, exp_val, act_val);
         mismatch_o = mismatch_o + 1;
      end
   endtask

   task automatic compare_word(input logic [27:0] exp_w, input logic [27:0] act_w);
      compare_field("exc_valid_o",      4'(exp_w[27]),    4'(act_w[27]));
      compare_field("exc_cause_o",      exp_w[26:23],     act_w[26:23]);
      compare_field("is_mret_o",        4'(exp_w[22]),    4'(act_w[22]));
      compare_field("chip_sel_o",       4'(exp_w[21:20]), 4'(act_w[21:20]));
      compare_field("csr_en_o",         4'(exp_w[19]),    4'(act_w[19]));
      compare_field("csr_op_o",         4'(exp_w[18:17]), 4'(act_w[18:17]));
      compare_field("csr_src_sel_o",    4'(exp_w[16]),    4'(act_w[16]));
      compare_field("alu_op_o",         exp_w[15:12],     act_w[15:12]);
      compare_field("mdu_en_o",         4'(exp_w[11]),    4'(act_w[11]));
      compare_field("mdu_op_o",         4'(exp_w[10:8]),  4'(act_w[10:8]));
      compare_field("rs2_negate_sel_o", 4'(exp_w[7]),     4'(act_w[7]));
      compare_field("reg_wr_en_o",      4'(exp_w[6]),     4'(act_w[6]));
      compare_field("wb_sel_o",         4'(exp_w[5:4]),   4'(act_w[5:4]));
      compare_field("op1_sel_o",        4'(exp_w[3]),     4'(act_w[3]));
      compare_field("op2_sel_o",        4'(exp_w[2]),     4'(act_w[2]));
      compare_field("is_load_o",        4'(exp_w[1]),     4'(act_w[1]));
      compare_field("is_store_o",       4'(exp_w[0]),     4'(act_w[0]));
   endtask

   always @(posedge clk_i) begin
      if (rst_i) begin
         pending_q.delete();
         pushed_last = 1'b0;
         checked_o  = 0;
         mismatch_o = 0;
         protocol_o = 0;
         end_done_o <= 1'b0;
      end else begin
         if (dut_valid_i === 1'b1 && pending_q.size() != 0) begin
            exp_word = pending_q.pop_front();
            compare_word(exp_word, act_word_i);
            checked_o = checked_o + 1;
         end else if (pushed_last) begin
            // Vector pushed last cycle is due now
            $display("valid_o did not rise one cycle after vector %0d was sampled",
                     checked_o + pending_q.size() - 1);
            protocol_o = protocol_o + 1;
         end else if (dut_valid_i !== 1'b0) begin
            $display("valid_o is %b while no vector is in flight", dut_valid_i);
            protocol_o = protocol_o + 1;
         end
         if (exp_push_i) begin
            pending_q.push_back(exp_word_i);
         end
         pushed_last = exp_push_i;
         if (end_i && !end_done_o) begin
            if (pending_q.size() != 0) begin
               $display("%0d expected results were never produced by the DUT",
                        pending_q.size());
               protocol_o = protocol_o + 1;
            end
            end_done_o <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* test/decode_testdata.txt */
# instr m_en | exc cause mret chip csr_en csr_op csr_src alu mdu_en mdu_op neg wr wb op1 op2 ld st
# all columns hex, instr is the full 32-bit word, text after the 19th column is ignored
00510093 1 0 0 0 0 0 0 0 0 0 0 0 1 0 0 1 0 0  # ADDI
00123193 1 0 0 0 0 0 0 0 5 0 0 0 1 0 0 1 0 0  # SLTIU
40335293 0 0 0 0 0 0 0 0 8 0 0 0 1 0 0 1 0 0  # SRAI
409403B3 1 0 0 0 0 0 0 0 1 0 0 1 1 0 0 0 0 0  # SUB
00C5F533 1 0 0 0 0 0 0 0 a 0 0 0 1 0 0 0 0 0  # AND
00F756B3 0 0 0 0 0 0 0 0 7 0 0 0 1 0 0 0 0 0  # SRL
00812083 1 0 0 0 0 0 0 0 0 0 0 0 1 1 0 1 1 0  # LW
00322623 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 1  # SW
00208863 1 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0  # BEQ
100000EF 1 0 0 0 0 0 0 0 0 0 0 0 1 3 1 1 0 0  # JAL
004280E7 1 0 0 0 0 0 0 0 0 0 0 0 1 3 0 1 0 0  # JALR
123452B7 1 0 0 0 0 0 0 0 c 0 0 0 1 0 0 1 0 0  # LUI
00001317 1 0 0 0 0 0 0 0 0 0 0 0 1 0 1 1 0 0  # AUIPC
023100B3 1 0 0 0 1 0 0 0 0 1 0 0 1 0 0 0 0 0  # MUL
0262D233 1 0 0 0 1 0 0 0 0 1 5 0 1 0 0 0 0 0  # DIVU
029473B3 1 0 0 0 1 0 0 0 0 1 7 0 1 0 0 0 0 0  # REMU
023100B3 0 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  # MUL, M disabled
0262D233 0 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  # DIVU, M disabled
029473B3 0 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  # REMU, M disabled
300110F3 1 0 0 0 3 1 1 0 0 0 0 0 1 0 0 0 0 0  # CSRRW
3412E1F3 1 0 0 0 3 1 2 1 0 0 0 0 1 0 0 0 0 0  # CSRRSI
00000073 1 1 b 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  # ECALL
00100073 1 1 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  # EBREAK
30200073 1 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0  # MRET
10500073 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  # WFI
0000000B 1 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  # unknown opcode
00013083 1 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  # load funct3 3
FE0000B3 1 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  # R-type funct7 0x7F
000000F3 1 1 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  # ECALL with rd 1

/* test/tb_decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;

   parameter int MAX_CYCLES = 0;
   localparam int MAX_VECTORS = 64;

   logic        clk_i;
   logic        rst_i;
   logic        valid_i;
   logic [31:2] instr_i;
   logic        m_ext_en_i;
   logic        valid_o;
   logic        exc_valid_o;
   logic [3:0]  exc_cause_o;
   logic        is_mret_o;
   logic [1:0]  chip_sel_o;
   logic        csr_en_o;
   logic [1:0]  csr_op_o;
   logic        csr_src_sel_o;
   logic [3:0]  alu_op_o;
   logic        mdu_en_o;
   logic [2:0]  mdu_op_o;
   logic        rs2_negate_sel_o;
   logic        reg_wr_en_o;
   logic [1:0]  wb_sel_o;
   logic        op1_sel_o;
   logic        op2_sel_o;
   logic        is_load_o;
   logic        is_store_o;

   logic        exp_push;
   logic [27:0] exp_word;
   logic        end_check;
   logic        end_done;
   int          checked;
   int          mismatches;
   int          protocol_errors;

   logic [31:0] vec_instr [MAX_VECTORS];
   logic        vec_m_en [MAX_VECTORS];
   logic [27:0] vec_exp [MAX_VECTORS];
   int          num_vectors;
   int          cycle_count = 0;
   int          cycle_limit = 0;
   integer      seed;
   logic        load_ok;

   initial clk_i = 1'b0;
   always #10 clk_i = ~clk_i;

   decode_stage u_decode_stage (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .valid_i          (valid_i),
      .instr_i          (instr_i),
      .m_ext_en_i       (m_ext_en_i),
      .valid_o          (valid_o),
      .exc_valid_o      (exc_valid_o),
      .exc_cause_o      (exc_cause_o),
      .is_mret_o        (is_mret_o),
      .chip_sel_o       (chip_sel_o),
      .csr_en_o         (csr_en_o),
      .csr_op_o         (csr_op_o),
      .csr_src_sel_o    (csr_src_sel_o),
      .alu_op_o         (alu_op_o),
      .mdu_en_o         (mdu_en_o),
      .mdu_op_o         (mdu_op_o),
      .rs2_negate_sel_o (rs2_negate_sel_o),
      .reg_wr_en_o      (reg_wr_en_o),
      .wb_sel_o         (wb_sel_o),
      .op1_sel_o        (op1_sel_o),
      .op2_sel_o        (op2_sel_o),
      .is_load_o        (is_load_o),
      .is_store_o       (is_store_o)
   );

   decode_checker u_checker (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .exp_push_i  (exp_push),
      .exp_word_i  (exp_word),
      .end_i       (end_check),
      .dut_valid_i (valid_o),
      .act_word_i  ({exc_valid_o, exc_cause_o, is_mret_o, chip_sel_o, csr_en_o, csr_op_o,
                     csr_src_sel_o, alu_op_o, mdu_en_o, mdu_op_o, rs2_negate_sel_o,
                     reg_wr_en_o, wb_sel_o, op1_sel_o, op2_sel_o, is_load_o, is_store_o}),
      .checked_o   (checked),
      .mismatch_o  (mismatches),
      .protocol_o  (protocol_errors),
      .end_done_o  (end_done)
   );

   always @(posedge clk_i) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Simulation failed");
         $finish;
      end
   end

   task automatic load_vectors(output logic ok);
      int          fd;
      int          n;
      string       line;
      logic [31:0] col [19];
      ok = 1'b1;
      num_vectors = 0;
      fd = $fopen("test/decode_testdata.txt", "r");
      if (fd == 0) begin
         $display("Cannot open test/decode_testdata.txt");
         ok = 1'b0;
      end else begin
         while ($fgets(line, fd) != 0) begin
            // Skip blank and comment lines
            if (line.len() < 2 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                        col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                        col[15], col[16], col[17], col[18]);
            if (n != 19 || num_vectors == MAX_VECTORS) begin
               $display("Bad or excess test data line: %s", line);
               ok = 1'b0;
            end else begin
               vec_instr[num_vectors] = col[0];
               vec_m_en[num_vectors]  = col[1][0];
               vec_exp[num_vectors]   = {col[2][0], col[3][3:0], col[4][0], col[5][1:0],
                                         col[6][0], col[7][1:0], col[8][0], col[9][3:0],
                                         col[10][0], col[11][2:0], col[12][0], col[13][0],
                                         col[14][1:0], col[15][0], col[16][0], col[17][0],
                                         col[18][0]};
               num_vectors = num_vectors + 1;
            end
         end
         $fclose(fd);
         if (num_vectors == 0) begin
            $display("Test data file holds no vectors");
            ok = 1'b0;
         end
      end
   endtask

   task automatic drive_vectors();
      int gap;
      for (int i = 0; i < num_vectors; i++) begin
         @(posedge clk_i);
         valid_i    <= 1'b1;
         instr_i    <= vec_instr[i][31:2];
         m_ext_en_i <= vec_m_en[i];
         exp_push   <= 1'b1;
         exp_word   <= vec_exp[i];
         // Zero to two idle cycles between vectors
         gap = {$random(seed)} % 3;
         repeat (gap) begin
            @(posedge clk_i);
            valid_i  <= 1'b0;
            exp_push <= 1'b0;
         end
      end
      @(posedge clk_i);
      valid_i  <= 1'b0;
      exp_push <= 1'b0;
   endtask

   initial begin
      seed       = 59288;
      rst_i      = 1'b1;
      valid_i    = 1'b0;
      instr_i    = '0;
      m_ext_en_i = 1'b0;
      exp_push   = 1'b0;
      exp_word   = '0;
      end_check  = 1'b0;
      load_vectors(load_ok);
      if (!load_ok) begin
         $display("Test data could not be loaded");
         $display("Simulation failed");
         $finish;
      end else begin
         cycle_limit = (MAX_CYCLES > 0) ? MAX_CYCLES : 3 * num_vectors + 100;
         repeat (8) @(posedge clk_i);
         rst_i <= 1'b0;
         // valid_o must stay low through these idle cycles
         repeat (2) @(posedge clk_i);
         drive_vectors();
         // Last result is due one cycle after the final vector is sampled
         end_check <= 1'b1;
         while (!end_done) @(posedge clk_i);
         $display("Checked %0d of %0d vectors: %0d mismatches, %0d protocol errors",
                  checked, num_vectors, mismatches, protocol_errors);
         if (mismatches == 0 && protocol_errors == 0 && checked == num_vectors) begin
            $display("Simulation completed successfully");
         end else begin
            $display("Simulation failed");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire
